// File: compile.f
hdl/icache_pkg.sv
hdl/line_store.sv
hdl/mshr_queue.sv
hdl/miss_alloc.sv
hdl/fill_replay.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_sva.sv
testbench/tb_icache.sv

// File: hdl/fill_replay.sv
`timescale 1ns/1ns
`default_nettype none

module fill_replay #(
  parameter int MSHR_COUNT = 4
) (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     lc_fill_valid,
  output logic                     lc_fill_ready,
  input  icache_pkg::fill_t        lc_fill,
  output logic                     store_we,
  output icache_pkg::fill_t        store_fill,
  input  logic [MSHR_COUNT-1:0]    busy,
  input  icache_pkg::block_addr_t  block [MSHR_COUNT],
  input  logic [MSHR_COUNT-1:0]    empty,
  input  icache_pkg::miss_entry_t  head [MSHR_COUNT],
  output logic [MSHR_COUNT-1:0]    deq,
  output logic [MSHR_COUNT-1:0]    release_en,
  output logic                     rep_valid,
  input  logic                     rep_ready,
  output icache_pkg::fetch_resp_t  rep
);

  icache_pkg::replay_state_t  state_q;
  icache_pkg::replay_state_t  state_d;
  logic [MSHR_COUNT-1:0]      sel_q;
  logic [MSHR_COUNT-1:0]      fill_match;
  icache_pkg::line_t          line_q;
  icache_pkg::miss_entry_t    sel_head;
  logic                       sel_empty;
  logic                       fill_take;
  logic                       ready_q;

  always_comb begin
    sel_head = '0;
    for (int i = 0; i < MSHR_COUNT; i++) begin
      fill_match[i] = busy[i] && (block[i] == lc_fill.block);
      if (sel_q[i]) begin
        sel_head = head[i];
      end
    end
  end

  assign sel_empty     = ~|(sel_q & ~empty);
  // fill port opens one cycle after reset
  assign lc_fill_ready = ready_q;
  assign fill_take     = lc_fill_valid && lc_fill_ready;

  // the store takes the fill on the same edge as the handshake
  assign store_we   = fill_take;
  assign store_fill = lc_fill;

  assign rep_valid  = (state_q == icache_pkg::DRAIN) && !sel_empty;
  assign rep        = '{addr: sel_head.addr, line: line_q};
  assign deq        = (rep_valid && rep_ready) ? sel_q : '0;
  assign release_en = ((state_q == icache_pkg::RELEASE) && sel_empty) ? sel_q : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::WAIT_FILL: begin
        // a fill nobody waits for only updates the store
        if (fill_take && (|fill_match)) begin
          state_d = icache_pkg::DRAIN;
        end
      end
      icache_pkg::DRAIN: begin
        if (sel_empty) begin
          state_d = icache_pkg::RELEASE;
        end
      end
      icache_pkg::RELEASE: begin
        // a late secondary miss sends us back to drain
        state_d = sel_empty ? icache_pkg::WAIT_FILL : icache_pkg::DRAIN;
      end
      default: begin
        state_d = icache_pkg::WAIT_FILL;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= icache_pkg::WAIT_FILL;
      sel_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == icache_pkg::WAIT_FILL);
      if (fill_take) begin
        sel_q <= fill_match;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (fill_take) begin
      line_q <= lc_fill.line;
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     fetch_valid,
  output logic                     fetch_ready,
  input  icache_pkg::paddr_t       fetch_addr,
  output logic                     lookup_valid,
  output icache_pkg::paddr_t       lookup_addr,
  input  logic                     hit,
  input  icache_pkg::line_t        line,
  output logic                     miss_valid,
  output icache_pkg::paddr_t       miss_addr,
  input  logic                     miss_ready,
  input  logic                     rep_valid,
  output logic                     rep_ready,
  input  icache_pkg::fetch_resp_t  rep,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output icache_pkg::fetch_resp_t  resp
);

  icache_pkg::ctrl_state_t  state_q;
  icache_pkg::ctrl_state_t  state_d;
  icache_pkg::paddr_t       fetch_q;
  logic                     pend_q;
  logic                     pend_d;
  logic                     resp_valid_q;
  icache_pkg::fetch_resp_t  resp_q;
  logic                     resp_free;
  logic                     load_en;
  icache_pkg::fetch_resp_t  load_data;

  // response register can take a new entry this cycle
  assign resp_free = !resp_valid_q || resp_ready;

  always_comb begin
    state_d      = state_q;
    pend_d       = pend_q;
    fetch_ready  = 1'b0;
    lookup_valid = 1'b0;
    lookup_addr  = fetch_addr;
    miss_valid   = 1'b0;
    miss_addr    = fetch_q;
    rep_ready    = 1'b0;
    load_en      = 1'b0;
    load_data    = rep;

    case (state_q)
      icache_pkg::IDLE: begin
        fetch_ready  = 1'b1;
        lookup_valid = fetch_valid;
        rep_ready    = resp_free;
        load_en      = rep_valid && resp_free;
        if (fetch_valid) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        load_data = '{addr: fetch_q, line: line};
        if (hit) begin
          load_en = resp_free;
          pend_d  = !resp_free;
          state_d = icache_pkg::RESPOND;
        end else begin
          state_d = icache_pkg::MISS;
        end
      end
      icache_pkg::MISS: begin
        miss_valid = 1'b1;
        // replays keep flowing so a full queue can drain while we stall
        rep_ready  = resp_free;
        load_en    = rep_valid && resp_free;
        if (miss_ready) begin
          state_d = icache_pkg::IDLE;
        end
      end
      icache_pkg::RESPOND: begin
        load_data = '{addr: fetch_q, line: line};
        if (pend_q) begin
          // a replay response still owns the port
          if (resp_free) begin
            load_en = 1'b1;
            pend_d  = 1'b0;
          end
        end else if (resp_ready) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q      <= icache_pkg::IDLE;
      pend_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pend_q  <= pend_d;
      if (load_en) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (load_en) begin
      resp_q <= load_data;
    end
    if (fetch_ready && fetch_valid) begin
      fetch_q <= fetch_addr;
    end
  end

  assign resp_valid = resp_valid_q;
  assign resp       = resp_q;

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  localparam int PADDR_BITS  = 22;
  localparam int LINE_BYTES  = 64;
  localparam int LINE_BITS   = LINE_BYTES * 8;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int BLOCK_BITS  = PADDR_BITS - OFFSET_BITS;

  typedef logic [PADDR_BITS-1:0] paddr_t;
  typedef logic [BLOCK_BITS-1:0] block_addr_t;
  typedef logic [LINE_BITS-1:0]  line_t;

  // one response to the fetch side
  typedef struct packed {
    paddr_t addr;
    line_t  line;
  } fetch_resp_t;

  // line returned by the lower cache
  typedef struct packed {
    block_addr_t block;
    line_t       line;
  } fill_t;

  // pending fetch waiting on a block
  typedef struct packed {
    paddr_t addr;
  } miss_entry_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MISS,
    RESPOND
  } ctrl_state_t;

  typedef enum logic [1:0] {
    WAIT_FILL,
    DRAIN,
    RELEASE
  } replay_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top #(
  parameter int SETS        = 64,
  parameter int MSHR_COUNT  = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     fetch_valid,
  output logic                     fetch_ready,
  input  icache_pkg::paddr_t       fetch_addr,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output icache_pkg::fetch_resp_t  resp,
  output logic                     lc_req_valid,
  input  logic                     lc_req_ready,
  output icache_pkg::block_addr_t  lc_req_block,
  input  logic                     lc_fill_valid,
  output logic                     lc_fill_ready,
  input  icache_pkg::fill_t        lc_fill
);

  logic                     lookup_valid;
  icache_pkg::paddr_t       lookup_addr;
  logic                     hit;
  icache_pkg::line_t        line;
  logic                     store_we;
  icache_pkg::fill_t        store_fill;
  logic                     miss_valid;
  icache_pkg::paddr_t       miss_addr;
  logic                     miss_ready;
  logic                     rep_valid;
  logic                     rep_ready;
  icache_pkg::fetch_resp_t  rep;

  // per-queue MSHR signals
  logic [MSHR_COUNT-1:0]    alloc;
  logic [MSHR_COUNT-1:0]    enq;
  icache_pkg::miss_entry_t  enq_entry;
  logic [MSHR_COUNT-1:0]    deq;
  logic [MSHR_COUNT-1:0]    release_en;
  logic [MSHR_COUNT-1:0]    busy;
  icache_pkg::block_addr_t  block [MSHR_COUNT];
  logic [MSHR_COUNT-1:0]    full;
  logic [MSHR_COUNT-1:0]    empty;
  icache_pkg::miss_entry_t  head [MSHR_COUNT];

  icache_ctrl u_ctrl (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .fetch_addr   (fetch_addr),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .line         (line),
    .miss_valid   (miss_valid),
    .miss_addr    (miss_addr),
    .miss_ready   (miss_ready),
    .rep_valid    (rep_valid),
    .rep_ready    (rep_ready),
    .rep          (rep),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp         (resp)
  );

  line_store #(
    .SETS (SETS)
  ) u_store (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .store_we     (store_we),
    .store_fill   (store_fill),
    .hit          (hit),
    .line         (line)
  );

  miss_alloc #(
    .MSHR_COUNT (MSHR_COUNT)
  ) u_alloc (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .miss_valid   (miss_valid),
    .miss_addr    (miss_addr),
    .miss_ready   (miss_ready),
    .busy         (busy),
    .block        (block),
    .full         (full),
    .alloc        (alloc),
    .enq          (enq),
    .enq_entry    (enq_entry),
    .lc_req_valid (lc_req_valid),
    .lc_req_ready (lc_req_ready),
    .lc_req_block (lc_req_block)
  );

  for (genvar i = 0; i < MSHR_COUNT; i++) begin : mshr_queues
    mshr_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
      .clk_in     (clk_in),
      .rst_N_in   (rst_N_in),
      .alloc      (alloc[i]),
      .enq        (enq[i]),
      .enq_entry  (enq_entry),
      .deq        (deq[i]),
      .release_en (release_en[i]),
      .busy       (busy[i]),
      .block      (block[i]),
      .full       (full[i]),
      .empty      (empty[i]),
      .head       (head[i])
    );
  end

  fill_replay #(
    .MSHR_COUNT (MSHR_COUNT)
  ) u_replay (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .lc_fill_valid (lc_fill_valid),
    .lc_fill_ready (lc_fill_ready),
    .lc_fill       (lc_fill),
    .store_we      (store_we),
    .store_fill    (store_fill),
    .busy          (busy),
    .block         (block),
    .empty         (empty),
    .head          (head),
    .deq           (deq),
    .release_en    (release_en),
    .rep_valid     (rep_valid),
    .rep_ready     (rep_ready),
    .rep           (rep)
  );

endmodule

`default_nettype wire

// File: hdl/line_store.sv
`timescale 1ns/1ns
`default_nettype none

module line_store #(
  parameter int SETS = 64
) (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  lookup_valid,
  input  icache_pkg::paddr_t    lookup_addr,
  input  logic                  store_we,
  input  icache_pkg::fill_t     store_fill,
  output logic                  hit,
  output icache_pkg::line_t     line
);

  localparam int IDX_BITS = $clog2(SETS);
  localparam int IDX_W    = (IDX_BITS > 0) ? IDX_BITS : 1;
  localparam int TAG_W    = icache_pkg::BLOCK_BITS - IDX_BITS;

  logic [SETS-1:0]          valid_q;
  logic [TAG_W-1:0]         tag_mem [SETS];
  icache_pkg::line_t        line_mem [SETS];

  icache_pkg::block_addr_t  look_blk;
  logic [IDX_W-1:0]         look_idx;
  logic [IDX_W-1:0]         fill_idx;
  logic                     hit_q;
  icache_pkg::line_t        line_q;

  function automatic logic [IDX_W-1:0] set_of(icache_pkg::block_addr_t blk);
    return IDX_W'(blk % SETS);
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(icache_pkg::block_addr_t blk);
    return TAG_W'(blk >> IDX_BITS);
  endfunction

  assign look_blk = lookup_addr[icache_pkg::PADDR_BITS-1:icache_pkg::OFFSET_BITS];
  assign look_idx = set_of(look_blk);
  assign fill_idx = set_of(store_fill.block);

  // tag compare on the read edge, a same-edge fill is seen one cycle later
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      hit_q   <= 1'b0;
    end else begin
      if (store_we) begin
        valid_q[fill_idx] <= 1'b1;
      end
      if (lookup_valid) begin
        hit_q <= valid_q[look_idx] && (tag_mem[look_idx] == tag_of(look_blk));
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (store_we) begin
      tag_mem[fill_idx]  <= tag_of(store_fill.block);
      line_mem[fill_idx] <= store_fill.line;
    end
    if (lookup_valid) begin
      line_q <= line_mem[look_idx];
    end
  end

  assign hit  = hit_q;
  assign line = line_q;

endmodule

`default_nettype wire

// File: hdl/miss_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module miss_alloc #(
  parameter int MSHR_COUNT = 4
) (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     miss_valid,
  input  icache_pkg::paddr_t       miss_addr,
  output logic                     miss_ready,
  input  logic [MSHR_COUNT-1:0]    busy,
  input  icache_pkg::block_addr_t  block [MSHR_COUNT],
  input  logic [MSHR_COUNT-1:0]    full,
  output logic [MSHR_COUNT-1:0]    alloc,
  output logic [MSHR_COUNT-1:0]    enq,
  output icache_pkg::miss_entry_t  enq_entry,
  output logic                     lc_req_valid,
  input  logic                     lc_req_ready,
  output icache_pkg::block_addr_t  lc_req_block
);

  icache_pkg::block_addr_t  miss_blk;
  logic [MSHR_COUNT-1:0]    match_vec;
  logic [MSHR_COUNT-1:0]    free_vec;
  logic [MSHR_COUNT-1:0]    free_oh;
  logic                     matched;
  logic                     take;
  logic                     primary;
  logic                     req_valid_q;
  icache_pkg::block_addr_t  req_block_q;

  assign miss_blk = miss_addr[icache_pkg::PADDR_BITS-1:icache_pkg::OFFSET_BITS];

  always_comb begin
    for (int i = 0; i < MSHR_COUNT; i++) begin
      match_vec[i] = busy[i] && (block[i] == miss_blk);
    end
  end

  assign matched  = |match_vec;
  assign free_vec = ~busy;
  // lowest free queue as a one-hot
  assign free_oh  = free_vec & (~free_vec + 1'b1);

  // secondary miss only needs room in its queue
  // primary miss needs a free queue and an idle request port
  assign miss_ready = matched ? !(|(match_vec & full)) : ((|free_vec) && !req_valid_q);
  assign take       = miss_valid && miss_ready;
  assign primary    = take && !matched;

  assign enq       = take ? (matched ? match_vec : free_oh) : '0;
  assign alloc     = primary ? free_oh : '0;
  assign enq_entry = '{addr: miss_addr};

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      req_valid_q <= 1'b0;
    end else if (primary) begin
      req_valid_q <= 1'b1;
    end else if (lc_req_ready) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (primary) begin
      req_block_q <= miss_blk;
    end
  end

  assign lc_req_valid = req_valid_q;
  assign lc_req_block = req_block_q;

endmodule

`default_nettype wire

// File: hdl/mshr_queue.sv
`timescale 1ns/1ns
`default_nettype none

module mshr_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     alloc,
  input  logic                     enq,
  input  icache_pkg::miss_entry_t  enq_entry,
  input  logic                     deq,
  input  logic                     release_en,
  output logic                     busy,
  output icache_pkg::block_addr_t  block,
  output logic                     full,
  output logic                     empty,
  output icache_pkg::miss_entry_t  head
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  icache_pkg::miss_entry_t  mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W-1:0]         wr_ptr;
  logic [CNT_W-1:0]         count;
  logic                     busy_q;
  icache_pkg::block_addr_t  block_q;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      busy_q <= 1'b0;
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (release_en) begin
        busy_q <= 1'b0;
      end
      // a new allocation wins over a release in the same cycle
      if (alloc) begin
        busy_q <= 1'b1;
      end
      if (enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (enq && !deq) begin
        count <= count + 1'b1;
      end else if (deq && !enq) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (enq) begin
      mem[wr_ptr] <= enq_entry;
    end
    if (alloc) begin
      block_q <= enq_entry.addr[icache_pkg::PADDR_BITS-1:icache_pkg::OFFSET_BITS];
    end
  end

  assign busy  = busy_q;
  assign block = block_q;
  // a queue being released takes no new entry
  assign full  = (count == CNT_W'(QUEUE_DEPTH)) || release_en;
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert --top-module tb_icache \
  -f compile.f -o sim_icache \
  && ./obj_dir/sim_icache > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: testbench/icache_sva.sv
`timescale 1ns/1ns
`default_nettype none

module icache_sva (
  input wire logic                     clk_in,
  input wire logic                     rst_N_in,
  input wire logic                     resp_valid,
  input wire logic                     resp_ready,
  input wire icache_pkg::fetch_resp_t  resp,
  input wire logic                     lc_req_valid,
  input wire logic                     lc_req_ready,
  input wire icache_pkg::block_addr_t  lc_req_block,
  input wire logic                     lc_fill_ready
);

  int unsigned fail_count = 0;

  // outputs come up quiet after reset
  reset_quiet: assert property (@(posedge clk_in)
    !rst_N_in |=> (!resp_valid && !lc_req_valid && !lc_fill_ready))
  else begin
    fail_count++;
    $error("response valid, request valid or fill ready high right after reset");
  end

  // a response waiting on resp_ready holds still
  resp_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
  else begin
    fail_count++;
    $error("response dropped or changed before its transfer");
  end

  req_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (lc_req_valid && !lc_req_ready) |=> (lc_req_valid && $stable(lc_req_block)))
  else begin
    fail_count++;
    $error("lower-cache request dropped or changed before its transfer");
  end

  // a taken request drops on the next cycle
  req_once: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (lc_req_valid && lc_req_ready) |=> !lc_req_valid)
  else begin
    fail_count++;
    $error("lower-cache request still valid after its transfer");
  end

endmodule

bind icache_top icache_sva sva_i (
  .clk_in        (clk_in),
  .rst_N_in      (rst_N_in),
  .resp_valid    (resp_valid),
  .resp_ready    (resp_ready),
  .resp          (resp),
  .lc_req_valid  (lc_req_valid),
  .lc_req_ready  (lc_req_ready),
  .lc_req_block  (lc_req_block),
  .lc_fill_ready (lc_fill_ready)
);

`default_nettype wire

// File: testbench/tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icache;

  localparam int SETS        = 64;
  localparam int MSHR_COUNT  = 4;
  localparam int QUEUE_DEPTH = 4;
  localparam int N_FETCH     = 400;
  localparam longint WATCHDOG_NS = longint'((8 + N_FETCH * 60) * 8);
  localparam icache_pkg::line_t LINE_KEY = {16{32'h9e37_79b9}};

  logic                     clk_in;
  logic                     rst_N_in;
  logic                     fetch_valid;
  logic                     fetch_ready;
  icache_pkg::paddr_t       fetch_addr;
  logic                     resp_valid;
  logic                     resp_ready;
  icache_pkg::fetch_resp_t  resp;
  logic                     lc_req_valid;
  logic                     lc_req_ready;
  icache_pkg::block_addr_t  lc_req_block;
  logic                     lc_fill_valid;
  logic                     lc_fill_ready;
  icache_pkg::fill_t        lc_fill;

  logic [31:0]              lfsr = 32'h54424cdc;
  int unsigned              errors = 0;
  int unsigned              fetches = 0;
  int unsigned              responses = 0;
  int unsigned              hit_fetches = 0;
  int                       pending [icache_pkg::paddr_t];
  icache_pkg::block_addr_t  outstanding [$];
  icache_pkg::block_addr_t  fill_fifo [$];
  bit                       miss_flag [0:65535];
  bit                       res_valid [0:SETS-1];
  icache_pkg::block_addr_t  res_blk [0:SETS-1];

  icache_top #(
    .SETS        (SETS),
    .MSHR_COUNT  (MSHR_COUNT),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready),
    .fetch_addr    (fetch_addr),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp          (resp),
    .lc_req_valid  (lc_req_valid),
    .lc_req_ready  (lc_req_ready),
    .lc_req_block  (lc_req_block),
    .lc_fill_valid (lc_fill_valid),
    .lc_fill_ready (lc_fill_ready),
    .lc_fill       (lc_fill)
  );

  initial clk_in = 1'b0;
  always #4 clk_in = ~clk_in;

  // taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic icache_pkg::line_t line_for(icache_pkg::block_addr_t b);
    return {32{b}} ^ LINE_KEY;
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic note_fetch(icache_pkg::paddr_t a);
    icache_pkg::block_addr_t blk;
    int set;
    blk = a[21:6];
    set = int'(blk[5:0]);
    if (pending.exists(a)) begin
      pending[a] = pending[a] + 1;
    end else begin
      pending[a] = 1;
    end
    fetches++;
    if (res_valid[set] && res_blk[set] == blk) begin
      hit_fetches++;
    end else begin
      miss_flag[blk] = 1'b1;
    end
  endtask

  task automatic check_resp(icache_pkg::fetch_resp_t r);
    icache_pkg::block_addr_t blk;
    blk = r.addr[21:6];
    responses++;
    assert (pending.exists(r.addr))
    else report_error($sformatf("response for address %h that has no open fetch", r.addr));
    if (pending.exists(r.addr)) begin
      pending[r.addr] = pending[r.addr] - 1;
      if (pending[r.addr] == 0) begin
        pending.delete(r.addr);
      end
    end
    assert (r.line == line_for(blk))
    else report_error($sformatf("mismatch resp.line addr %h: got %h expected %h",
                                r.addr, r.line, line_for(blk)));
  endtask

  task automatic note_request(icache_pkg::block_addr_t blk);
    bit dup;
    dup = 1'b0;
    foreach (outstanding[i]) begin
      if (outstanding[i] == blk) begin
        dup = 1'b1;
      end
    end
    // a resident block never goes back to the lower cache
    assert (miss_flag[blk])
    else report_error($sformatf("request for block %h with no fetch that missed", blk));
    miss_flag[blk] = 1'b0;
    assert (!dup)
    else report_error($sformatf("block %h requested again while still outstanding", blk));
    assert (outstanding.size() < MSHR_COUNT)
    else report_error("more lower-cache requests outstanding than there are MSHRs");
    outstanding.push_back(blk);
    fill_fifo.push_back(blk);
  endtask

  task automatic note_fill(icache_pkg::block_addr_t blk);
    int idx;
    idx = -1;
    foreach (outstanding[i]) begin
      if (outstanding[i] == blk && idx < 0) begin
        idx = i;
      end
    end
    assert (idx >= 0)
    else report_error($sformatf("fill for block %h that was never requested", blk));
    if (idx >= 0) begin
      outstanding.delete(idx);
    end
    res_valid[int'(blk[5:0])] = 1'b1;
    res_blk[int'(blk[5:0])]   = blk;
  endtask

  // fetch before fill, so a same-edge fill counts as a miss
  always @(posedge clk_in) begin
    if (rst_N_in) begin
      if (fetch_valid && fetch_ready) begin
        note_fetch(fetch_addr);
      end
      if (resp_valid && resp_ready) begin
        check_resp(resp);
      end
      if (lc_req_valid && lc_req_ready) begin
        note_request(lc_req_block);
      end
      if (lc_fill_valid && lc_fill_ready) begin
        note_fill(lc_fill.block);
      end
    end
  end

  // random back-pressure, ready about three times in four
  always @(negedge clk_in) begin
    resp_ready   = (rand_bits(2) != 0);
    lc_req_ready = (rand_bits(2) != 0);
  end

  // lower-cache model, fills back in request order
  initial begin : lower_cache
    int gap;
    icache_pkg::block_addr_t blk;
    lc_fill_valid = 1'b0;
    lc_fill       = '0;
    @(posedge rst_N_in);
    forever begin
      @(negedge clk_in);
      if (fill_fifo.size() != 0) begin
        gap = int'(rand_bits(4));
        repeat (gap) @(negedge clk_in);
        blk           = fill_fifo.pop_front();
        lc_fill       = '{block: blk, line: line_for(blk)};
        lc_fill_valid = 1'b1;
        while (!lc_fill_ready) @(negedge clk_in);
        @(negedge clk_in);
        lc_fill_valid = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired before all fetches were answered");
    $display(">>> FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] r;
    int gap;
    resp_ready   = 1'b0;
    lc_req_ready = 1'b0;
    fetch_valid  = 1'b0;
    fetch_addr   = '0;
    rst_N_in     = 1'b0;
    repeat (8) @(negedge clk_in);
    rst_N_in = 1'b1;
    for (int n = 0; n < N_FETCH; n++) begin
      gap = int'(rand_bits(2));
      repeat (gap) @(negedge clk_in);
      // 16 blocks over 8 sets, two per set
      r           = rand_bits(10);
      fetch_addr  = {(r[3] ? 10'h2a8 : 10'h005), 3'b000, r[2:0], r[9:4]};
      fetch_valid = 1'b1;
      while (!fetch_ready) @(negedge clk_in);
      @(negedge clk_in);
      fetch_valid = 1'b0;
    end
    while (responses < N_FETCH || outstanding.size() != 0) @(negedge clk_in);
    repeat (4) @(negedge clk_in);
    assert (responses == fetches && pending.num() == 0)
    else report_error($sformatf("mismatch responses: got %h expected %h", responses, fetches));
    errors += dut.sva_i.fail_count;
    $display("fetches %0d hits %0d responses %0d errors %0d",
             fetches, hit_fetches, responses, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
